// ==== Makefile ====
TOP = gomoku_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== hw/board_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface board_if;
    import gomoku_pkg::*;

    // combinational read port
    cell_idx_t rd_idx;
    cell_t     rd_cell;
    // write lands on the next edge
    logic      wr_en;
    cell_idx_t wr_idx;
    cell_t     wr_cell;

    modport engine (
        output rd_idx,
        input  rd_cell,
        output wr_en,
        output wr_idx,
        output wr_cell
    );

    modport store (
        input  rd_idx,
        output rd_cell,
        input  wr_en,
        input  wr_idx,
        input  wr_cell
    );

endinterface

`default_nettype wire

// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gomoku_cfg.svh"

module board_store (
    input wire     avm_clk,
    input wire     avm_rst,
    board_if.store brd
);
    import gomoku_pkg::*;

    cell_t cells [`GOMOKU_CELLS];
    logic  rd_in_range;
    logic  wr_in_range;

    assign rd_in_range = (brd.rd_idx < cell_idx_t'(`GOMOKU_CELLS));
    assign wr_in_range = (brd.wr_idx < cell_idx_t'(`GOMOKU_CELLS));

    // indices past the last cell read as empty
    assign brd.rd_cell = rd_in_range ? cells[brd.rd_idx] : CELL_EMPTY;

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            for (int i = 0; i < `GOMOKU_CELLS; i++) begin
                cells[i] <= CELL_EMPTY;
            end
        end else begin
            if (brd.wr_en && wr_in_range) begin
                cells[brd.wr_idx] <= brd.wr_cell;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gomoku_pkg.sv ====
`default_nettype none

package gomoku_pkg;

    // cell contents, empty after reset
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_OWN   = 2'd1,
        CELL_OPP   = 2'd2
    } cell_t;

    // move byte as sent over the uart
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } move_t;

    // linear index, row * 15 + col
    typedef logic [7:0] cell_idx_t;

endpackage

`default_nettype wire

// ==== hw/gomoku_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gomoku_top (
    input wire          avm_clk,
    input wire          avm_rst,
    output logic [4:0]  address,
    output logic        read,
    input wire [31:0]   readdata,
    output logic        write,
    output logic [31:0] writedata,
    input wire          waitrequest
);

    // one turn in flight between bridge and engine
    move_if turn_if ();

    // board access, engine side only
    board_if brd_if ();

    uart_host_bridge uart_host_bridge_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .turn        (turn_if.bridge)
    );

    move_engine move_engine_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .turn    (turn_if.engine),
        .brd     (brd_if.engine)
    );

    board_store board_store_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .brd     (brd_if.store)
    );

endmodule

`default_nettype wire

// ==== hw/move_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gomoku_cfg.svh"

module move_engine (
    input wire      avm_clk,
    input wire      avm_rst,
    move_if.engine  turn,
    board_if.engine brd
);
    import gomoku_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_SCAN
    } state_t;

    state_t     state;
    move_t      move_r;
    move_t      reply_r;
    logic       done_r;
    cell_idx_t  opp_idx;
    cell_idx_t  scan_idx;
    logic [3:0] row_cnt;
    logic [3:0] col_cnt;
    logic       out_of_range;
    logic       board_full;
    logic       take_opp;
    logic       take_own;

    // row * 15 + col, at most 240 so 8 bits suffice
    assign opp_idx = cell_idx_t'(move_r.row) * cell_idx_t'(`GOMOKU_BOARD_DIM)
                   + cell_idx_t'(move_r.col);

    assign out_of_range = (move_r.row >= 4'(`GOMOKU_BOARD_DIM))
                       || (move_r.col >= 4'(`GOMOKU_BOARD_DIM));
    assign board_full   = (scan_idx == cell_idx_t'(`GOMOKU_CELLS));

    assign take_opp = (state == ST_CHECK) && !out_of_range && (brd.rd_cell == CELL_EMPTY);
    assign take_own = (state == ST_SCAN) && !board_full && (brd.rd_cell == CELL_EMPTY);

    assign turn.done  = done_r;
    assign turn.reply = reply_r;

    always_comb begin
        brd.rd_idx  = opp_idx;
        brd.wr_en   = take_opp;
        brd.wr_idx  = opp_idx;
        brd.wr_cell = CELL_OPP;
        if (state == ST_SCAN) begin
            brd.rd_idx  = scan_idx;
            brd.wr_en   = take_own;
            brd.wr_idx  = scan_idx;
            brd.wr_cell = CELL_OWN;
        end
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state    <= ST_IDLE;
            done_r   <= 1'b0;
            scan_idx <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
        end else begin
            done_r <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (turn.start) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (take_opp) begin
                        state    <= ST_SCAN;
                        scan_idx <= '0;
                        row_cnt  <= '0;
                        col_cnt  <= '0;
                    end else begin
                        // reject, done two cycles after start
                        done_r <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                ST_SCAN: begin
                    if (take_own || board_full) begin
                        done_r <= 1'b1;
                        state  <= ST_IDLE;
                    end else begin
                        scan_idx <= scan_idx + 8'd1;
                        // row/col follow the index, no divide
                        if (col_cnt == 4'(`GOMOKU_BOARD_DIM - 1)) begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + 4'd1;
                        end else begin
                            col_cnt <= col_cnt + 4'd1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == ST_IDLE && turn.start) begin
            move_r <= turn.move_in;
        end
        if (state == ST_CHECK && !take_opp) begin
            reply_r <= move_t'(`GOMOKU_REPLY_REJECT);
        end
        if (take_own) begin
            reply_r <= '{row: row_cnt, col: col_cnt};
        end else if (state == ST_SCAN && board_full) begin
            reply_r <= move_t'(`GOMOKU_REPLY_FULL);
        end
    end

endmodule

`default_nettype wire

// ==== hw/move_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface move_if;
    import gomoku_pkg::*;

    logic  start;
    move_t move_in;
    logic  done;
    // valid in the done cycle only
    move_t reply;

    modport bridge (
        output start,
        output move_in,
        input  done,
        input  reply
    );

    modport engine (
        input  start,
        input  move_in,
        output done,
        output reply
    );

endinterface

`default_nettype wire

// ==== hw/uart_host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gomoku_cfg.svh"

module uart_host_bridge (
    input wire          avm_clk,
    input wire          avm_rst,
    output logic [4:0]  address,
    output logic        read,
    input wire [31:0]   readdata,
    output logic        write,
    output logic [31:0] writedata,
    input wire          waitrequest,
    move_if.bridge      turn
);
    import gomoku_pkg::*;

    typedef enum logic [2:0] {
        ST_RX_POLL,
        ST_RX_READ,
        ST_WAIT_ENG,
        ST_TX_POLL,
        ST_TX_WRITE
    } state_t;

    state_t state;
    logic   start_r;
    move_t  rx_move;
    move_t  tx_move;
    logic   xfer_done;

    // a transfer completes on the first cycle without waitrequest
    assign xfer_done = (read || write) && !waitrequest;

    assign turn.start   = start_r;
    assign turn.move_in = rx_move;
    assign writedata    = {24'd0, tx_move};

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state   <= ST_RX_POLL;
            address <= `GOMOKU_STATUS_ADDR;
            read    <= 1'b0;
            write   <= 1'b0;
            start_r <= 1'b0;
        end else begin
            start_r <= 1'b0;
            case (state)
                ST_RX_POLL: begin
                    if (!read) begin
                        // first poll after reset
                        read    <= 1'b1;
                        address <= `GOMOKU_STATUS_ADDR;
                    end else if (xfer_done && readdata[`GOMOKU_RX_OK_BIT]) begin
                        address <= `GOMOKU_RX_ADDR;
                        state   <= ST_RX_READ;
                    end
                end
                ST_RX_READ: begin
                    if (xfer_done) begin
                        read    <= 1'b0;
                        address <= `GOMOKU_STATUS_ADDR;
                        start_r <= 1'b1;
                        state   <= ST_WAIT_ENG;
                    end
                end
                ST_WAIT_ENG: begin
                    if (turn.done) begin
                        read    <= 1'b1;
                        address <= `GOMOKU_STATUS_ADDR;
                        state   <= ST_TX_POLL;
                    end
                end
                ST_TX_POLL: begin
                    if (xfer_done && readdata[`GOMOKU_TX_OK_BIT]) begin
                        read    <= 1'b0;
                        write   <= 1'b1;
                        address <= `GOMOKU_TX_ADDR;
                        state   <= ST_TX_WRITE;
                    end
                end
                ST_TX_WRITE: begin
                    if (xfer_done) begin
                        // straight back to receive polling
                        write   <= 1'b0;
                        read    <= 1'b1;
                        address <= `GOMOKU_STATUS_ADDR;
                        state   <= ST_RX_POLL;
                    end
                end
                default: begin
                    read    <= 1'b0;
                    write   <= 1'b0;
                    address <= `GOMOKU_STATUS_ADDR;
                    state   <= ST_RX_POLL;
                end
            endcase
        end
    end

    // received and reply bytes
    always_ff @(posedge avm_clk) begin
        if (state == ST_RX_READ && xfer_done) begin
            rx_move <= move_t'(readdata[7:0]);
        end
        if (state == ST_WAIT_ENG && turn.done) begin
            tx_move <= turn.reply;
        end
    end

endmodule

`default_nettype wire

// ==== include/gomoku_cfg.svh ====
`ifndef GOMOKU_CFG_SVH
`define GOMOKU_CFG_SVH

// board geometry
`define GOMOKU_BOARD_DIM 15
`define GOMOKU_CELLS     225

// uart register byte offsets
`define GOMOKU_RX_ADDR     5'd0
`define GOMOKU_TX_ADDR     5'd4
`define GOMOKU_STATUS_ADDR 5'd8

// status register bits
`define GOMOKU_TX_OK_BIT 6
`define GOMOKU_RX_OK_BIT 7

// special reply bytes
`define GOMOKU_REPLY_REJECT 8'hff
`define GOMOKU_REPLY_FULL   8'hfe

`endif

// ==== project.f ====
+incdir+include
hw/gomoku_pkg.sv
hw/move_if.sv
hw/board_if.sv
hw/board_store.sv
hw/move_engine.sv
hw/uart_host_bridge.sv
hw/gomoku_top.sv
verification/gomoku_checker.sv
verification/gomoku_tb.sv

// ==== verification/gomoku_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gomoku_cfg.svh"

module gomoku_checker (
    input wire        avm_clk,
    input wire        avm_rst,
    input wire [4:0]  address,
    input wire        read,
    input wire [31:0] readdata,
    input wire        write,
    input wire [31:0] writedata,
    input wire        waitrequest,
    output int        errors,
    output int        replies,
    output int        rx_reads,
    output int        taken_rejects,
    output int        fulls
);
    import gomoku_pkg::*;

    cell_t      ref_board [`GOMOKU_CELLS];
    logic       pending;
    logic [7:0] pending_move;
    logic [7:0] expected;

    // applies one opponent move to the reference board and returns the reply byte
    function automatic logic [7:0] predict_reply(input logic [7:0] mv);
        int row;
        int col;
        int idx;
        int own;
        row = int'(mv[7:4]);
        col = int'(mv[3:0]);
        if (row >= `GOMOKU_BOARD_DIM || col >= `GOMOKU_BOARD_DIM) begin
            return `GOMOKU_REPLY_REJECT;
        end
        idx = row * `GOMOKU_BOARD_DIM + col;
        if (ref_board[idx] != CELL_EMPTY) begin
            return `GOMOKU_REPLY_REJECT;
        end
        ref_board[idx] = CELL_OPP;
        own = -1;
        for (int i = 0; i < `GOMOKU_CELLS && own < 0; i++) begin
            if (ref_board[i] == CELL_EMPTY) begin
                own = i;
            end
        end
        if (own < 0) begin
            return `GOMOKU_REPLY_FULL;
        end
        ref_board[own] = CELL_OWN;
        return {4'(own / `GOMOKU_BOARD_DIM), 4'(own % `GOMOKU_BOARD_DIM)};
    endfunction

    always @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            for (int i = 0; i < `GOMOKU_CELLS; i++) begin
                ref_board[i] = CELL_EMPTY;
            end
            pending       = 1'b0;
            errors        = 0;
            replies       = 0;
            rx_reads      = 0;
            taken_rejects = 0;
            fulls         = 0;
        end else begin
            if (read && !waitrequest && address == `GOMOKU_RX_ADDR) begin
                rx_reads++;
                if (pending) begin
                    errors++;
                    $display("second receive read before the reply to move %02h was sent",
                             pending_move);
                end
                pending_move = readdata[7:0];
                expected     = predict_reply(readdata[7:0]);
                pending      = 1'b1;
                if (expected == `GOMOKU_REPLY_REJECT) begin
                    // in range, so the named cell was already taken
                    if (int'(pending_move[7:4]) < `GOMOKU_BOARD_DIM
                        && int'(pending_move[3:0]) < `GOMOKU_BOARD_DIM) begin
                        taken_rejects++;
                    end
                end else if (expected == `GOMOKU_REPLY_FULL) begin
                    fulls++;
                end
            end
            if (write && !waitrequest) begin
                replies++;
                if (address != `GOMOKU_TX_ADDR) begin
                    errors++;
                    $display("error address expected %02h got %02h", `GOMOKU_TX_ADDR, address);
                end
                if (writedata[31:8] != 24'd0) begin
                    errors++;
                    $display("error writedata[31:8] expected 000000 got %06h", writedata[31:8]);
                end
                if (!pending) begin
                    errors++;
                    $display("transmit write of %02h with no opponent move pending",
                             writedata[7:0]);
                end else begin
                    if (writedata[7:0] != expected) begin
                        errors++;
                        $display("error writedata expected %02h got %02h (move %02h)",
                                 expected, writedata[7:0], pending_move);
                    end
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/gomoku_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "gomoku_cfg.svh"

module gomoku_tb;
    import gomoku_pkg::*;

    localparam int NUM_MOVES       = 150;
    localparam int CYCLES_PER_MOVE = 600;
    localparam int CYCLE_LIMIT     = NUM_MOVES * CYCLES_PER_MOVE;
    localparam int SEED            = 38;

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  address;
    logic        read;
    logic [31:0] readdata;
    logic        write;
    logic [31:0] writedata;
    logic        waitrequest;

    // uart model state
    logic [7:0] rx_queue [$];
    cell_t      gen_board [`GOMOKU_CELLS];
    logic       rx_ready;
    logic       tx_ready;
    int         rx_gap;
    int         tx_gap;

    int         cycles;
    int         tb_errors;
    logic       timed_out;
    int         chk_errors;
    int         replies;
    int         rx_reads;
    int         taken_rejects;
    int         fulls;

    gomoku_top gomoku_top_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest)
    );

    gomoku_checker gomoku_checker_i (
        .avm_clk       (avm_clk),
        .avm_rst       (avm_rst),
        .address       (address),
        .read          (read),
        .readdata      (readdata),
        .write         (write),
        .writedata     (writedata),
        .waitrequest   (waitrequest),
        .errors        (chk_errors),
        .replies       (replies),
        .rx_reads      (rx_reads),
        .taken_rejects (taken_rejects),
        .fulls         (fulls)
    );

    initial begin
        avm_clk = 1'b0;
        forever #2 avm_clk = ~avm_clk;
    end

    // index of the n-th cell that is empty (or taken)
    function automatic int nth_cell(input logic want_empty, input int n);
        int seen;
        seen = 0;
        for (int i = 0; i < `GOMOKU_CELLS; i++) begin
            if ((gen_board[i] == CELL_EMPTY) == want_empty) begin
                if (seen == n) begin
                    return i;
                end
                seen++;
            end
        end
        return 0;
    endfunction

    task automatic build_moves();
        int         empty_cnt;
        int         idx;
        int         own;
        logic [3:0] row;
        logic [7:0] mv;
        empty_cnt = `GOMOKU_CELLS;
        for (int i = 0; i < `GOMOKU_CELLS; i++) begin
            gen_board[i] = CELL_EMPTY;
        end
        for (int n = 0; n < NUM_MOVES; n++) begin
            if (empty_cnt == 0 || $urandom_range(7, 0) == 0) begin
                if (empty_cnt == `GOMOKU_CELLS || $urandom_range(1, 0) == 0) begin
                    // row or column 15
                    row = 4'($urandom_range(15, 0));
                    mv  = ($urandom_range(1, 0) == 0) ? {row, 4'hf} : {4'hf, row};
                end else begin
                    idx = nth_cell(1'b0, int'($urandom_range(`GOMOKU_CELLS - empty_cnt - 1, 0)));
                    mv  = {4'(idx / `GOMOKU_BOARD_DIM), 4'(idx % `GOMOKU_BOARD_DIM)};
                end
            end else begin
                idx = nth_cell(1'b1, int'($urandom_range(empty_cnt - 1, 0)));
                mv  = {4'(idx / `GOMOKU_BOARD_DIM), 4'(idx % `GOMOKU_BOARD_DIM)};
                gen_board[idx] = CELL_OPP;
                empty_cnt--;
                // the engine takes the lowest free cell
                if (empty_cnt != 0) begin
                    own = nth_cell(1'b1, 0);
                    gen_board[own] = CELL_OWN;
                    empty_cnt--;
                end
            end
            rx_queue.push_back(mv);
        end
    endtask

    // uart slave answering the transfer that completes at the next rising edge
    always @(negedge avm_clk) begin
        if (!rx_ready && rx_queue.size() != 0) begin
            if (rx_gap == 0) begin
                rx_ready = 1'b1;
            end else begin
                rx_gap--;
            end
        end
        if (!tx_ready) begin
            if (tx_gap == 0) begin
                tx_ready = 1'b1;
            end else begin
                tx_gap--;
            end
        end
        waitrequest = ($urandom_range(3, 0) == 0);
        readdata    = '0;
        if (read && address == `GOMOKU_STATUS_ADDR) begin
            readdata[`GOMOKU_RX_OK_BIT] = rx_ready;
            readdata[`GOMOKU_TX_OK_BIT] = tx_ready;
        end else if (read && address == `GOMOKU_RX_ADDR && rx_queue.size() != 0) begin
            readdata[7:0] = rx_queue[0];
        end
        if (read && !waitrequest && address == `GOMOKU_RX_ADDR) begin
            if (rx_queue.size() != 0) begin
                void'(rx_queue.pop_front());
            end
            rx_ready = 1'b0;
            rx_gap   = int'($urandom_range(12, 0));
        end
        if (write && !waitrequest && address == `GOMOKU_TX_ADDR) begin
            tx_ready = 1'b0;
            tx_gap   = int'($urandom_range(12, 0));
        end
    end

    initial begin
        void'($urandom(SEED));
        avm_rst     = 1'b0;
        readdata    = '0;
        waitrequest = 1'b0;
        rx_ready    = 1'b0;
        tx_ready    = 1'b0;
        rx_gap      = 0;
        tx_gap      = 0;
        tb_errors   = 0;
        timed_out   = 1'b0;
        cycles      = 0;
        build_moves();
        repeat (4) @(negedge avm_clk);
        avm_rst = 1'b1;

        while (replies < NUM_MOVES && !timed_out) begin
            @(negedge avm_clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout after %0d cycles, only %0d of %0d moves answered",
                         cycles, replies, NUM_MOVES);
            end
        end
        // let any stray transfer show up
        repeat (20) @(negedge avm_clk);

        if (timed_out) begin
            tb_errors++;
        end else begin
            if (rx_reads != replies || rx_queue.size() != 0) begin
                tb_errors++;
                $display("receive reads (%0d) and transmit writes (%0d) do not pair up",
                         rx_reads, replies);
            end
            if (fulls != 1) begin
                tb_errors++;
                $display("expected exactly one full-board reply but saw %0d", fulls);
            end
            if (taken_rejects == 0) begin
                tb_errors++;
                $display("no move on an occupied cell was exercised");
            end
        end

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
